// ==== hdl/accel_pkg.sv ====
package accel_pkg;

   // the request selector is taken from the low address bits
   localparam int sel_width_c = 2;

   // where an inbound write request goes
   typedef enum logic [sel_width_c-1:0]
   {
      // tag placed in the address field of outgoing packets
      SEL_ADDR = 2'd0,
      // y and x coordinates of the outgoing packets
      SEL_DEST = 2'd1,
      // send the data word out as a write packet
      SEL_FWD  = 2'd2,
      // unmapped, consumed and dropped
      SEL_NONE = 2'd3
   } target_sel_e;

   // bits needed to count from zero up to and including max_val
   function automatic int cnt_width_f(input int max_val);
      int width;
      width = $clog2(max_val + 1);
      return (width < 1) ? 1 : width;
   endfunction

   // bits needed to index a storage of els entries
   function automatic int ptr_width_f(input int els);
      int width;
      width = $clog2(els);
      return (width < 1) ? 1 : width;
   endfunction

endpackage

// ==== hdl/accel_req_fifo.sv ====
`timescale 1ns/1ps

module accel_req_fifo
  #(parameter int data_width_p = 32
    , parameter int addr_width_p = 16
    , parameter int fifo_els_p = 4
    )
   (input  logic                    clk_i
    , input  logic                    arst_n_i

    // inbound requests, limited by the sender's credits
    , input  logic                    in_v_i
    , input  logic [addr_width_p-1:0] in_addr_i
    , input  logic [data_width_p-1:0] in_data_i

    // head of the queue toward the decoder
    , output logic                    head_v_o
    , output logic [addr_width_p-1:0] head_addr_o
    , output logic [data_width_p-1:0] head_data_o
    , input  logic                    head_yumi_i

    // one pulse per freed entry
    , output logic                    in_credit_o
    );

   import accel_pkg::*;

   localparam int ptr_width_lp = ptr_width_f(fifo_els_p);
   localparam int cnt_width_lp = cnt_width_f(fifo_els_p);

   logic [addr_width_p-1:0] addr_mem [fifo_els_p];
   logic [data_width_p-1:0] data_mem [fifo_els_p];

   logic [ptr_width_lp-1:0] wr_ptr_r;
   logic [ptr_width_lp-1:0] rd_ptr_r;
   logic [cnt_width_lp-1:0] count_r;
   logic                    full;
   logic                    enq;
   logic                    deq;

   // pointers wrap at the depth, which need not be a power of two
   function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
      logic [ptr_width_lp-1:0] nxt;
      if (ptr == ptr_width_lp'(fifo_els_p - 1))
         nxt = '0;
      else
         nxt = ptr + 1'b1;
      return nxt;
   endfunction

   assign full     = (count_r == cnt_width_lp'(fifo_els_p));
   assign head_v_o = (count_r != '0);

   // a write into a full queue is dropped
   assign enq = in_v_i & ~full;
   assign deq = head_yumi_i & head_v_o;

   assign head_addr_o = addr_mem[rd_ptr_r];
   assign head_data_o = data_mem[rd_ptr_r];

   // storage
   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         addr_mem[wr_ptr_r] <= in_addr_i;
         data_mem[wr_ptr_r] <= in_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r    <= '0;
         rd_ptr_r    <= '0;
         count_r     <= '0;
         in_credit_o <= 1'b0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (deq)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         if (enq && !deq)
            count_r <= count_r + 1'b1;
         else if (deq && !enq)
            count_r <= count_r - 1'b1;
         // credit goes back the cycle after the pop
         in_credit_o <= deq;
      end
   end

endmodule

// ==== hdl/accel_csr_decode.sv ====
`timescale 1ns/1ps

module accel_csr_decode
  #(parameter int data_width_p = 32
    , parameter int addr_width_p = 16
    , parameter int x_cord_width_p = 4
    , parameter int y_cord_width_p = 4
    )
   (input  logic                      clk_i
    , input  logic                      arst_n_i

    // request at the head of the inbound queue
    , input  logic                      head_v_i
    , input  logic [addr_width_p-1:0]   head_addr_i
    , input  logic [data_width_p-1:0]   head_data_i
    , output logic                      head_yumi_o

    // forward handshake
    , input  logic                      fwd_ready_i
    , output logic                      fwd_v_o

    // stored packet configuration
    , output logic [addr_width_p-1:0]   pkt_addr_o
    , output logic [x_cord_width_p-1:0] pkt_dest_x_o
    , output logic [y_cord_width_p-1:0] pkt_dest_y_o
    );

   import accel_pkg::*;

   localparam int yx_width_lp = y_cord_width_p + x_cord_width_p;

   target_sel_e sel;
   logic        addr_we;
   logic        dest_we;

   assign sel = target_sel_e'(head_addr_i[sel_width_c-1:0]);

   always_comb
   begin
      addr_we     = 1'b0;
      dest_we     = 1'b0;
      fwd_v_o     = 1'b0;
      head_yumi_o = 1'b0;
      unique case (sel)
         SEL_ADDR:
         begin
            addr_we     = head_v_i;
            head_yumi_o = head_v_i;
         end
         SEL_DEST:
         begin
            dest_we     = head_v_i;
            head_yumi_o = head_v_i;
         end
         SEL_FWD:
         begin
            // held at the head until an outbound credit is available
            fwd_v_o     = head_v_i & fwd_ready_i;
            head_yumi_o = head_v_i & fwd_ready_i;
         end
         SEL_NONE:
         begin
            // unmapped target, just eat it
            head_yumi_o = head_v_i;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         pkt_addr_o   <= '0;
         pkt_dest_x_o <= '0;
         pkt_dest_y_o <= '0;
      end
      else
      begin
         if (addr_we)
            pkt_addr_o <= head_data_i[addr_width_p-1:0];
         // x sits in the lowest bits, y right above it
         if (dest_we)
            {pkt_dest_y_o, pkt_dest_x_o} <= head_data_i[yx_width_lp-1:0];
      end
   end

endmodule

// ==== hdl/accel_forward.sv ====
`timescale 1ns/1ps

module accel_forward
  #(parameter int data_width_p = 32
    , parameter int addr_width_p = 16
    , parameter int x_cord_width_p = 4
    , parameter int y_cord_width_p = 4
    , parameter int out_credits_p = 3
    )
   (input  logic                      clk_i
    , input  logic                      arst_n_i

    // forward request from the decoder
    , input  logic                      fwd_v_i
    , input  logic [data_width_p-1:0]   fwd_data_i
    , output logic                      fwd_ready_o

    // packet configuration in force
    , input  logic [addr_width_p-1:0]   pkt_addr_i
    , input  logic [x_cord_width_p-1:0] pkt_dest_x_i
    , input  logic [y_cord_width_p-1:0] pkt_dest_y_i

    // outgoing write packet, full word
    , output logic                      out_v_o
    , output logic [addr_width_p-1:0]   out_addr_o
    , output logic [x_cord_width_p-1:0] out_dest_x_o
    , output logic [y_cord_width_p-1:0] out_dest_y_o
    , output logic [data_width_p-1:0]   out_data_o

    // credit returned by the receiver
    , input  logic                      out_credit_i
    );

   import accel_pkg::*;

   localparam int credit_width_lp = cnt_width_f(out_credits_p);

   logic [credit_width_lp-1:0] credit_cnt_r;
   logic                       send;

   // the decoder raises fwd_v_i only while a credit is left
   assign send        = fwd_v_i;
   assign fwd_ready_o = (credit_cnt_r != '0);

   // outbound credit counter
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credit_cnt_r <= credit_width_lp'(out_credits_p);
      end
      else
      begin
         // send and return together leave it unchanged
         if (send && !out_credit_i)
            credit_cnt_r <= credit_cnt_r - 1'b1;
         else if (out_credit_i && !send)
            credit_cnt_r <= credit_cnt_r + 1'b1;
      end
   end

   // one-cycle strobe
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         out_v_o <= 1'b0;
      else
         out_v_o <= send;
   end

   // packet fields are qualified by out_v_o
   always_ff @(posedge clk_i)
   begin
      if (send)
      begin
         out_addr_o   <= pkt_addr_i;
         out_dest_x_o <= pkt_dest_x_i;
         out_dest_y_o <= pkt_dest_y_i;
         out_data_o   <= fwd_data_i;
      end
   end

endmodule

// ==== hdl/accel_top.sv ====
`timescale 1ns/1ps

module accel_top
  #(parameter int data_width_p = 32
    , parameter int addr_width_p = 16
    , parameter int x_cord_width_p = 4
    , parameter int y_cord_width_p = 4
    , parameter int fifo_els_p = 4
    , parameter int out_credits_p = 3
    )
   (input  logic                      clk_i
    , input  logic                      arst_n_i

    // inbound write requests
    , input  logic                      in_v_i
    , input  logic [addr_width_p-1:0]   in_addr_i
    , input  logic [data_width_p-1:0]   in_data_i
    , output logic                      in_credit_o

    // outbound write packets
    , output logic                      out_v_o
    , output logic [addr_width_p-1:0]   out_addr_o
    , output logic [x_cord_width_p-1:0] out_dest_x_o
    , output logic [y_cord_width_p-1:0] out_dest_y_o
    , output logic [data_width_p-1:0]   out_data_o
    , input  logic                      out_credit_i
    );

   logic                      head_v;
   logic [addr_width_p-1:0]   head_addr;
   logic [data_width_p-1:0]   head_data;
   logic                      head_yumi;
   logic                      fwd_v;
   logic                      fwd_ready;
   logic [addr_width_p-1:0]   pkt_addr;
   logic [x_cord_width_p-1:0] pkt_dest_x;
   logic [y_cord_width_p-1:0] pkt_dest_y;

   // inbound queue, one credit per freed entry
   accel_req_fifo
     #(.data_width_p (data_width_p)
       ,.addr_width_p(addr_width_p)
       ,.fifo_els_p  (fifo_els_p)
       ) req_fifo
     (.clk_i        (clk_i)
      ,.arst_n_i    (arst_n_i)
      ,.in_v_i      (in_v_i)
      ,.in_addr_i   (in_addr_i)
      ,.in_data_i   (in_data_i)
      ,.head_v_o    (head_v)
      ,.head_addr_o (head_addr)
      ,.head_data_o (head_data)
      ,.head_yumi_i (head_yumi)
      ,.in_credit_o (in_credit_o)
      );

   accel_csr_decode
     #(.data_width_p   (data_width_p)
       ,.addr_width_p  (addr_width_p)
       ,.x_cord_width_p(x_cord_width_p)
       ,.y_cord_width_p(y_cord_width_p)
       ) csr_decode
     (.clk_i         (clk_i)
      ,.arst_n_i     (arst_n_i)
      ,.head_v_i     (head_v)
      ,.head_addr_i  (head_addr)
      ,.head_data_i  (head_data)
      ,.head_yumi_o  (head_yumi)
      ,.fwd_ready_i  (fwd_ready)
      ,.fwd_v_o      (fwd_v)
      ,.pkt_addr_o   (pkt_addr)
      ,.pkt_dest_x_o (pkt_dest_x)
      ,.pkt_dest_y_o (pkt_dest_y)
      );

   // the forwarded word comes straight from the queue head
   accel_forward
     #(.data_width_p   (data_width_p)
       ,.addr_width_p  (addr_width_p)
       ,.x_cord_width_p(x_cord_width_p)
       ,.y_cord_width_p(y_cord_width_p)
       ,.out_credits_p (out_credits_p)
       ) forward
     (.clk_i         (clk_i)
      ,.arst_n_i     (arst_n_i)
      ,.fwd_v_i      (fwd_v)
      ,.fwd_data_i   (head_data)
      ,.fwd_ready_o  (fwd_ready)
      ,.pkt_addr_i   (pkt_addr)
      ,.pkt_dest_x_i (pkt_dest_x)
      ,.pkt_dest_y_i (pkt_dest_y)
      ,.out_v_o      (out_v_o)
      ,.out_addr_o   (out_addr_o)
      ,.out_dest_x_o (out_dest_x_o)
      ,.out_dest_y_o (out_dest_y_o)
      ,.out_data_o   (out_data_o)
      ,.out_credit_i (out_credit_i)
      );

endmodule

// ==== test/accel_sva.sv ====
`timescale 1ns/1ps

module accel_sva
  #(parameter int out_credits_p = 3
    , parameter int cnt_width_p = 2
    )
   (input  logic                   clk_i
    , input  logic                   arst_n_i
    , input  logic                   out_v_i
    , input  logic [cnt_width_p-1:0] credit_cnt_i
    , input  logic                   credit_ret_i
    , input  logic                   send_i
    , input  logic                   in_v_i
    , input  logic                   full_i
    );

   // a packet leaves only if a credit was held at the send edge
   send_needs_credit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_v_i |-> ($past(credit_cnt_i) != '0))
   else $error("packet strobe without an outbound credit");

   // a return without a send must find room below the maximum
   credit_bound_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (credit_ret_i && !send_i) |-> (credit_cnt_i < cnt_width_p'(out_credits_p)))
   else $error("outbound credit count above its maximum");

   // sender must respect its inbound credits
   no_write_when_full_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      in_v_i |-> !full_i)
   else $error("request written into a full FIFO");

endmodule

bind accel_forward accel_sva
  #(.out_credits_p (out_credits_p)
    ,.cnt_width_p  (credit_width_lp)
    ) forward_sva
  (.clk_i         (clk_i)
   ,.arst_n_i     (arst_n_i)
   ,.out_v_i      (out_v_o)
   ,.credit_cnt_i (credit_cnt_r)
   ,.credit_ret_i (out_credit_i)
   ,.send_i       (send)
   ,.in_v_i       (1'b0)
   ,.full_i       (1'b0)
   );

bind accel_req_fifo accel_sva
  #(.out_credits_p (1)
    ,.cnt_width_p  (1)
    ) fifo_sva
  (.clk_i         (clk_i)
   ,.arst_n_i     (arst_n_i)
   ,.out_v_i      (1'b0)
   ,.credit_cnt_i (1'b0)
   ,.credit_ret_i (1'b0)
   ,.send_i       (1'b0)
   ,.in_v_i       (in_v_i)
   ,.full_i       (full)
   );

// ==== test/accel_tb.sv ====
`timescale 1ns/1ps

module accel_tb;

   import accel_pkg::*;

   localparam int data_width_c  = 32;
   localparam int addr_width_c  = 16;
   localparam int x_width_c     = 4;
   localparam int y_width_c     = 4;
   localparam int fifo_els_c    = 4;
   localparam int out_credits_c = 3;
   localparam int pkt_width_c   = data_width_c + addr_width_c + y_width_c + x_width_c;
   localparam int num_reqs_c    = 300;
   // up to 40 cycles per request, margin for the directed parts
   localparam int watchdog_cycles_c = num_reqs_c * 40 + 2000;
   localparam int wait_limit_c  = 300;

   logic                    clk_i;
   logic                    arst_n_i;
   logic                    in_v_i;
   logic [addr_width_c-1:0] in_addr_i;
   logic [data_width_c-1:0] in_data_i;
   logic                    in_credit_o;
   logic                    out_v_o;
   logic [addr_width_c-1:0] out_addr_o;
   logic [x_width_c-1:0]    out_dest_x_o;
   logic [y_width_c-1:0]    out_dest_y_o;
   logic [data_width_c-1:0] out_data_o;
   logic                    out_credit_i;

   // reference model state
   logic [addr_width_c-1:0] tag_m;
   logic [x_width_c-1:0]    dest_x_m;
   logic [y_width_c-1:0]    dest_y_m;
   logic [pkt_width_c-1:0]  exp_q [$];

   int    seed;
   int    cyc = 0;
   int    out_cyc = 0;
   int    out_cnt = 0;
   int    ret_cnt = 0;
   int    credit_pulses = 0;
   int    req_sent = 0;
   int    value_errs = 0;
   int    proto_errs = 0;
   int    withhold_left;
   int    return_pct;
   string test_name;

   accel_top
     #(.data_width_p   (data_width_c)
       ,.addr_width_p  (addr_width_c)
       ,.x_cord_width_p(x_width_c)
       ,.y_cord_width_p(y_width_c)
       ,.fifo_els_p    (fifo_els_c)
       ,.out_credits_p (out_credits_c)
       ) accel_top_inst (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // forwards dominate the mix
   function automatic target_sel_e pick_sel();
      int r;
      r = rand_below(8);
      case (r)
         0: return SEL_ADDR;
         1: return SEL_DEST;
         2: return SEL_NONE;
         default: return SEL_FWD;
      endcase
   endfunction

   task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      value_errs++;
      $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
   endtask

   task automatic report_proto(input string msg);
      proto_errs++;
      $display("%s: %s", test_name, msg);
   endtask

   // next edge, then drive after a short hold
   task automatic tick();
      @(posedge clk_i);
      #2;
      in_v_i = 1'b0;
      if (withhold_left > 0)
      begin
         withhold_left--;
         out_credit_i = 1'b0;
      end
      else
         out_credit_i = (out_cnt > ret_cnt) && (rand_below(100) < return_pct);
   endtask

   task automatic send_req(input target_sel_e sel, input logic [data_width_c-1:0] data);
      int                      guard;
      logic [addr_width_c-1:0] addr;
      guard = 0;
      while (fifo_els_c + credit_pulses - req_sent <= 0 && guard < wait_limit_c)
      begin
         tick();
         guard++;
      end
      if (guard == wait_limit_c)
         report_proto("no inbound credit came back");
      addr = addr_width_c'($random(seed));
      addr[sel_width_c-1:0] = sel;
      in_v_i    = 1'b1;
      in_addr_i = addr;
      in_data_i = data;
      req_sent++;
      case (sel)
         SEL_ADDR: tag_m = data[addr_width_c-1:0];
         SEL_DEST:
         begin
            dest_x_m = data[x_width_c-1:0];
            dest_y_m = data[x_width_c+y_width_c-1:x_width_c];
         end
         // tag and destination as they stand at issue
         SEL_FWD: exp_q.push_back({data, tag_m, dest_y_m, dest_x_m});
         default: ;
      endcase
      tick();
   endtask

   // return every credit until nothing is left in flight
   task automatic drain();
      int guard;
      guard = 0;
      withhold_left = 0;
      return_pct = 100;
      while ((exp_q.size() != 0 || credit_pulses != req_sent || out_cnt != ret_cnt)
             && guard < wait_limit_c)
      begin
         tick();
         guard++;
      end
      if (guard == wait_limit_c)
         report_proto("traffic did not drain");
   endtask

   task automatic check_idle_latency(input logic [data_width_c-1:0] data);
      int issue_cyc;
      int start_cnt;
      int guard;
      drain();
      repeat (3) tick();
      start_cnt = out_cnt;
      send_req(SEL_FWD, data);
      // now just past the sampling edge
      issue_cyc = cyc;
      guard = 0;
      while (out_cnt == start_cnt && guard < 20)
      begin
         tick();
         guard++;
      end
      if (out_cnt == start_cnt)
         report_proto("no packet after a forward on an idle tile");
      else
         assert (out_cyc - issue_cyc == 2)
         else report_value("latency", 2, out_cyc - issue_cyc);
   endtask

   always @(posedge clk_i)
   begin : monitor
      logic [pkt_width_c-1:0] got;
      cyc++;
      if (!arst_n_i)
      begin
         assert (!out_v_o && !in_credit_o)
         else report_proto("strobe high while in reset");
      end
      else
      begin
         if (in_credit_o)
            credit_pulses++;
         if (out_credit_i)
            ret_cnt++;
         if (out_v_o)
         begin
            got = {out_data_o, out_addr_o, out_dest_y_o, out_dest_x_o};
            out_cnt++;
            out_cyc = cyc;
            if (exp_q.size() == 0)
               report_proto("packet sent with nothing in the expected queue");
            else
            begin
               assert (got == exp_q[0])
               else report_value("packet", exp_q[0], got);
               void'(exp_q.pop_front());
            end
         end
         assert (credit_pulses <= req_sent)
         else report_proto("inbound credit for an entry never sent");
         assert (out_cnt <= out_credits_c + ret_cnt)
         else report_proto("more packets than outbound credits allow");
      end
   end

   initial
   begin
      repeat (watchdog_cycles_c) @(posedge clk_i);
      $display("watchdog expired after %0d cycles", watchdog_cycles_c);
      $display("Some tests failed");
      $finish;
   end

   initial
   begin
      seed = 1874;
      arst_n_i = 1'b0;
      in_v_i = 1'b0;
      in_addr_i = '0;
      in_data_i = '0;
      out_credit_i = 1'b0;
      tag_m = '0;
      dest_x_m = '0;
      dest_y_m = '0;
      withhold_left = 0;
      return_pct = 60;
      test_name = "reset";
      repeat (10) @(posedge clk_i);
      #2;
      arst_n_i = 1'b1;
      repeat (4) tick();

      // config change between two forwards
      test_name = "configuration";
      send_req(SEL_ADDR, 32'h0000_1230);
      send_req(SEL_DEST, 32'h0000_0021);
      send_req(SEL_FWD, 32'hcafe_0001);
      send_req(SEL_ADDR, 32'h0000_4560);
      send_req(SEL_FWD, 32'hcafe_0002);
      send_req(SEL_DEST, 32'h0000_0035);
      send_req(SEL_NONE, 32'hdead_0000);
      send_req(SEL_FWD, 32'hcafe_0003);
      drain();

      test_name = "credit stall";
      withhold_left = 1000;
      for (int i = 0; i < 6; i++)
         send_req(SEL_FWD, 32'hbeef_0000 + i);
      repeat (20) tick();
      assert (out_cnt - ret_cnt == out_credits_c)
      else report_value("packets in flight", out_credits_c, out_cnt - ret_cnt);
      drain();

      test_name = "random traffic";
      return_pct = 60;
      for (int i = 0; i < num_reqs_c; i++)
      begin
         if (rand_below(50) == 0)
            withhold_left = 20 + rand_below(60);
         while (rand_below(4) == 0)
            tick();
         send_req(pick_sel(), $random(seed));
      end
      drain();

      test_name = "idle latency";
      repeat (3) check_idle_latency($random(seed));
      drain();

      test_name = "end of run";
      assert (exp_q.size() == 0)
      else report_value("expected queue size", 0, exp_q.size());
      assert (credit_pulses == req_sent)
      else report_value("inbound credits", req_sent, credit_pulses);
      $display("error counts: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== accel_default.f ====
hdl/accel_pkg.sv
hdl/accel_req_fifo.sv
hdl/accel_csr_decode.sv
hdl/accel_forward.sv
hdl/accel_top.sv
test/accel_sva.sv
test/accel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the accel testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module accel_tb \
   -f accel_default.f -o accel_sim > sim.log 2>&1 \
   && ./obj_dir/accel_sim >> sim.log 2>&1 \
   || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
